// File: fpu_pkg.sv
/*
 * Shared definitions of the floating-point execution unit
 * Widths and IEEE field constants, instruction word layout
 * Opcode, function and sub-function codes, latencies
 * Vector typedefs and the decoded operation enum
 */

`default_nettype none

package fpu_pkg;

	// ========================================================================
	// Widths and single-precision fields
	// ========================================================================
	localparam int VAL_W = 32;
	localparam int EXP_W = 8;
	localparam int MAN_W = 23;
	localparam int BIAS = 127;
	// Half precision bias, only needed when widening halves
	localparam int HALF_BIAS = 15;

	typedef logic [VAL_W-1:0] value_t;
	typedef logic [VAL_W-1:0] instr_t;
	// Opcode sits in ir[6:0], function codes are 6 bits wide
	typedef logic [6:0] opcode_t;
	typedef logic [5:0] func_t;
	// Latency of an operation in clock cycles
	typedef logic [1:0] lat_t;

	// Exponent offset between half and single precision
	localparam logic [EXP_W-1:0] H2S_EBIAS = EXP_W'(BIAS - HALF_BIAS);
	localparam value_t FP_ONE = 32'h3F80_0000;
	// Saturation limits of the float-to-int conversion
	localparam value_t INT_MAX = 32'h7FFF_FFFF;
	localparam value_t INT_MIN = 32'h8000_0000;

	// ========================================================================
	// Instruction codes
	// ========================================================================
	localparam opcode_t OP_FLT3 = 7'h51;

	localparam func_t FN_FLT1 = 6'h01;
	localparam func_t FN_FSEQ = 6'h08;
	localparam func_t FN_FSNE = 6'h09;
	localparam func_t FN_FSLT = 6'h0A;
	localparam func_t FN_FSLE = 6'h0B;
	localparam func_t FN_FCMP = 6'h0C;
	localparam func_t FN_SGNJ = 6'h10;
	localparam func_t FN_SGNJN = 6'h11;
	localparam func_t FN_SGNJX = 6'h12;

	// Sub-functions of the one-operand group
	localparam func_t FN_FABS = 6'h00;
	localparam func_t FN_FNEG = 6'h01;
	localparam func_t FN_FSIGN = 6'h02;
	localparam func_t FN_FTOI = 6'h03;
	localparam func_t FN_ISNAN = 6'h04;
	localparam func_t FN_FINITE = 6'h05;
	localparam func_t FN_FTRUNC = 6'h06;
	localparam func_t FN_FCVTH2S = 6'h07;

	localparam lat_t LAT_COMB = 2'd0;
	localparam lat_t LAT_FTRUNC = 2'd1;
	localparam lat_t LAT_FTOI = 2'd2;

	// One member per operation the unit carries out
	typedef enum logic [4:0] {
		OPX_NONE, OPX_FABS, OPX_FNEG, OPX_FSIGN,
		OPX_SGNJ, OPX_SGNJN, OPX_SGNJX,
		OPX_FSEQ, OPX_FSNE, OPX_FSLT, OPX_FSLE, OPX_FCMP,
		OPX_ISNAN, OPX_FINITE, OPX_FTOI, OPX_FTRUNC, OPX_FCVTH2S
	} fpu_op_e;

endpackage

`default_nettype wire

// File: fpu_op_if.sv
/*
 * Decoded operation interface
 * Operation, latency, start level and the two operands
 */

`timescale 1ns/1ps
`default_nettype none

interface fpu_op_if;
	import fpu_pkg::*;

	// Operation class resolved from the instruction word
	fpu_op_e op;
	lat_t lat;
	// High in any cycle where the inputs differ from the captured copy
	logic start;
	value_t a;
	value_t b;

	modport decode (output op, output lat, output start, output a, output b);

	// Execute only needs the operands and the operation to pick a result
	modport exec (input op, input a, input b);

	// Result times done from the latency and the start level
	modport result (input op, input lat, input start);

endinterface

`default_nettype wire

// File: fpu_cand_if.sv
/*
 * Candidate result interface
 * Combinational logic result plus the three converter outputs
 */

`timescale 1ns/1ps
`default_nettype none

interface fpu_cand_if;
	import fpu_pkg::*;

	// Sign, compare and classify result, already chosen by op
	value_t logic_res;
	// Two-cycle float-to-int result
	value_t ftoi_res;
	// One-cycle truncation result
	value_t trunc_res;
	// Combinational half-to-single result
	value_t h2s_res;

	modport exec (output logic_res, output ftoi_res, output trunc_res, output h2s_res);

	modport result (input logic_res, input ftoi_res, input trunc_res, input h2s_res);

endinterface

`default_nettype wire

// File: fpu_convert.sv
/*
 * Format converters on operand a
 * Two-stage float-to-int rounded toward zero with saturation
 * One-stage truncation to an integral float
 * Combinational half-to-single widening
 */

`timescale 1ns/1ps
`default_nettype none

module fpu_convert (
	input wire logic clk,
	input wire logic rst,
	input wire fpu_pkg::value_t a,
	output fpu_pkg::value_t ftoi,
	output fpu_pkg::value_t trunc,
	output fpu_pkg::value_t h2s
);
	import fpu_pkg::*;

	logic sgn;
	logic [EXP_W-1:0] exp;
	logic [MAN_W-1:0] frac;
	logic is_nan;
	logic [EXP_W-1:0] ftoi_sh;
	logic [VAL_W-2:0] ftoi_al;
	logic s1_sgn;
	logic s1_nan;
	logic s1_ovf;
	logic [VAL_W-2:0] s1_mag;
	logic [EXP_W-1:0] tr_sh;
	logic [MAN_W-1:0] tr_mask;
	logic h_sgn;
	logic [4:0] h_exp;
	logic [9:0] h_man;
	logic [3:0] h_lead;
	logic [10:0] h_norm;

	assign sgn = a[VAL_W-1];
	assign exp = a[VAL_W-2:MAN_W];
	assign frac = a[MAN_W-1:0];
	assign is_nan = (&exp) && (|frac);

	// ========================================================================
	// Float to int
	// ========================================================================
	// The hidden one lands in bit 30 for an exponent of BIAS+30
	assign ftoi_sh = EXP_W'(BIAS + VAL_W - 2) - exp;
	assign ftoi_al = {1'b1, frac, 7'd0} >> ftoi_sh[4:0];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			s1_sgn <= 1'b0;
			s1_nan <= 1'b0;
			s1_ovf <= 1'b0;
			s1_mag <= '0;
			ftoi <= '0;
		end else begin
			// Stage 1 aligns the magnitude, anything below 1 drops to zero
			s1_sgn <= sgn;
			s1_nan <= is_nan;
			s1_ovf <= (exp >= EXP_W'(BIAS + VAL_W - 1));
			if (exp < EXP_W'(BIAS)) begin
				s1_mag <= '0;
			end else begin
				s1_mag <= ftoi_al;
			end
			// Stage 2 applies the sign or saturates
			if (s1_nan) begin
				ftoi <= INT_MAX;
			end else if (s1_ovf) begin
				ftoi <= s1_sgn ? INT_MIN : INT_MAX;
			end else if (s1_sgn) begin
				ftoi <= ~{1'b0, s1_mag} + 1'b1;
			end else begin
				ftoi <= {1'b0, s1_mag};
			end
		end
	end

	// ========================================================================
	// Truncation
	// ========================================================================
	// Number of fraction bits that sit below the binary point
	assign tr_sh = EXP_W'(BIAS + MAN_W) - exp;
	assign tr_mask = {MAN_W{1'b1}} << tr_sh;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			trunc <= '0;
		end else if (exp < EXP_W'(BIAS)) begin
			trunc <= {sgn, {(VAL_W-1){1'b0}}};
		end else if (exp >= EXP_W'(BIAS + MAN_W)) begin
			// Already integral, or infinity or NaN
			trunc <= a;
		end else begin
			trunc <= {sgn, exp, frac & tr_mask};
		end
	end

	// ========================================================================
	// Half to single
	// ========================================================================
	assign h_sgn = a[15];
	assign h_exp = a[14:10];
	assign h_man = a[9:0];

	// Position of the leading one of a subnormal mantissa
	always_comb begin
		h_lead = 4'd0;
		for (int i = 0; i < 10; i++) begin
			if (h_man[i]) begin
				h_lead = 4'(i);
			end
		end
	end

	assign h_norm = {1'b0, h_man} << (4'd10 - h_lead);

	always_comb begin
		if (h_exp == 5'h1F) begin
			h2s = {h_sgn, {EXP_W{1'b1}}, h_man, 13'd0};
		end else if ((h_exp == 5'd0) && (h_man == 10'd0)) begin
			h2s = {h_sgn, {(VAL_W-1){1'b0}}};
		end else if (h_exp == 5'd0) begin
			// Subnormal value is h_man * 2^-24
			h2s = {h_sgn, H2S_EBIAS - 8'd9 + {4'd0, h_lead}, h_norm[9:0], 13'd0};
		end else begin
			h2s = {h_sgn, H2S_EBIAS + {3'd0, h_exp}, h_man, 13'd0};
		end
	end

endmodule

`default_nettype wire

// File: fpu_decode.sv
/*
 * Decode stage
 * Instruction classification and latency lookup
 * Argument-change detection that raises start
 */

`timescale 1ns/1ps
`default_nettype none

module fpu_decode (
	input wire logic clk,
	input wire logic rst,
	input wire fpu_pkg::instr_t ir,
	input wire fpu_pkg::value_t a,
	input wire fpu_pkg::value_t b,
	fpu_op_if.decode opi
);
	import fpu_pkg::*;

	opcode_t opc;
	func_t fn;
	func_t sub;
	fpu_op_e op;
	logic [3*VAL_W-1:0] args;
	logic [3*VAL_W-1:0] args_q;

	assign opc = ir[6:0];
	assign fn = ir[31:26];
	assign sub = ir[25:20];
	assign args = {ir, a, b};

	// Copy of the arguments as seen at the last rising edge
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			args_q <= '0;
		end else begin
			args_q <= args;
		end
	end

	// Any difference from the copy means a new operation has begun
	assign opi.start = (args != args_q);

	// ========================================================================
	// Classification
	// ========================================================================
	always_comb begin
		op = OPX_NONE;
		if (opc == OP_FLT3) begin
			case (fn)
				FN_FLT1: begin
					case (sub)
						FN_FABS: op = OPX_FABS;
						FN_FNEG: op = OPX_FNEG;
						FN_FSIGN: op = OPX_FSIGN;
						FN_FTOI: op = OPX_FTOI;
						FN_ISNAN: op = OPX_ISNAN;
						FN_FINITE: op = OPX_FINITE;
						FN_FTRUNC: op = OPX_FTRUNC;
						FN_FCVTH2S: op = OPX_FCVTH2S;
						default: op = OPX_NONE;
					endcase
				end
				FN_FSEQ: op = OPX_FSEQ;
				FN_FSNE: op = OPX_FSNE;
				FN_FSLT: op = OPX_FSLT;
				FN_FSLE: op = OPX_FSLE;
				FN_FCMP: op = OPX_FCMP;
				FN_SGNJ: op = OPX_SGNJ;
				FN_SGNJN: op = OPX_SGNJN;
				FN_SGNJX: op = OPX_SGNJX;
				default: op = OPX_NONE;
			endcase
		end
	end

	// Only the two pipelined converters take more than zero cycles
	always_comb begin
		case (op)
			OPX_FTOI: opi.lat = LAT_FTOI;
			OPX_FTRUNC: opi.lat = LAT_FTRUNC;
			default: opi.lat = LAT_COMB;
		endcase
	end

	assign opi.op = op;
	assign opi.a = a;
	assign opi.b = b;

endmodule

`default_nettype wire

// File: fpu_execute.sv
/*
 * Execute stage
 * Sign, sign-injection, compare and classify logic
 * Converter instance for float-to-int, truncation and half-to-single
 */

`timescale 1ns/1ps
`default_nettype none

module fpu_execute (
	input wire logic clk,
	input wire logic rst,
	fpu_op_if.exec opi,
	fpu_cand_if.exec cand
);
	import fpu_pkg::*;

	value_t a;
	value_t b;
	logic a_nan;
	logic b_nan;
	logic a_zero;
	logic b_zero;
	logic unord;
	logic eq;
	logic lt;
	logic le;
	value_t sign_res;

	assign a = opi.a;
	assign b = opi.b;

	// Pipelined and combinational converters all work on operand a
	fpu_convert u_convert (
		.clk(clk),
		.rst(rst),
		.a(a),
		.ftoi(cand.ftoi_res),
		.trunc(cand.trunc_res),
		.h2s(cand.h2s_res)
	);

	// NaN has an all-ones exponent and a nonzero fraction
	assign a_nan = (&a[30:23]) && (|a[22:0]);
	assign b_nan = (&b[30:23]) && (|b[22:0]);
	assign a_zero = (a[30:0] == '0);
	assign b_zero = (b[30:0] == '0);

	// Sign function, NaN passes through and both zeros give +0
	always_comb begin
		if (a_nan) begin
			sign_res = a;
		end else if (a_zero) begin
			sign_res = '0;
		end else begin
			sign_res = {a[31], FP_ONE[30:0]};
		end
	end

	// ========================================================================
	// Compares
	// ========================================================================
	assign unord = a_nan || b_nan;
	// +0 and -0 compare equal
	assign eq = !unord && ((a == b) || (a_zero && b_zero));

	always_comb begin
		if (unord || eq) begin
			lt = 1'b0;
		end else if (a[31] != b[31]) begin
			lt = a[31];
		end else if (a[31]) begin
			// Both negative, so the larger magnitude is the smaller value
			lt = (a[30:0] > b[30:0]);
		end else begin
			lt = (a[30:0] < b[30:0]);
		end
	end

	assign le = eq || lt;

	// Select the combinational result; converter ops are picked in result
	always_comb begin
		case (opi.op)
			OPX_FABS: cand.logic_res = {1'b0, a[30:0]};
			OPX_FNEG: cand.logic_res = {~a[31], a[30:0]};
			OPX_FSIGN: cand.logic_res = sign_res;
			OPX_SGNJ: cand.logic_res = {a[31], b[30:0]};
			OPX_SGNJN: cand.logic_res = {~a[31], b[30:0]};
			OPX_SGNJX: cand.logic_res = {a[31] ^ b[31], b[30:0]};
			OPX_FSEQ: cand.logic_res = {31'd0, eq};
			OPX_FSNE: cand.logic_res = {31'd0, ~eq};
			OPX_FSLT: cand.logic_res = {31'd0, lt};
			OPX_FSLE: cand.logic_res = {31'd0, le};
			// Flags are eq, lt, le and unordered from bit 0 upward
			OPX_FCMP: cand.logic_res = {28'd0, unord, le, lt, eq};
			OPX_ISNAN: cand.logic_res = {31'd0, a_nan};
			OPX_FINITE: cand.logic_res = {31'd0, ~&a[30:23]};
			default: cand.logic_res = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: fpu_result.sv
/*
 * Result stage
 * Saturating cycle counter, done timing and result selection
 */

`timescale 1ns/1ps
`default_nettype none

module fpu_result (
	input wire logic clk,
	input wire logic rst,
	input wire logic idle,
	fpu_op_if.result opi,
	fpu_cand_if.result cand,
	output fpu_pkg::value_t o,
	output logic done
);
	import fpu_pkg::*;

	lat_t cnt;

	// ========================================================================
	// Done timing
	// ========================================================================
	// Cleared at the edge that ends a start cycle, then counts up to 3
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (opi.start) begin
			cnt <= '0;
		end else if (cnt != 2'd3) begin
			cnt <= cnt + 2'd1;
		end
	end

	// A latency-L operation is done L edges after its inputs settle
	always_comb begin
		if (idle) begin
			done = 1'b0;
		end else if (opi.lat == LAT_COMB) begin
			done = 1'b1;
		end else begin
			done = !opi.start && (cnt >= opi.lat - 2'd1);
		end
	end

	// ========================================================================
	// Result selection
	// ========================================================================
	always_comb begin
		case (opi.op)
			OPX_FTOI: o = cand.ftoi_res;
			OPX_FTRUNC: o = cand.trunc_res;
			OPX_FCVTH2S: o = cand.h2s_res;
			// Unknown opcodes and functions return zero
			OPX_NONE: o = '0;
			default: o = cand.logic_res;
		endcase
	end

endmodule

`default_nettype wire

// File: fpu_top.sv
/*
 * Top level of the floating-point execution unit
 * Decode, execute and result stages joined by two interfaces
 */

`timescale 1ns/1ps
`default_nettype none

module fpu_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic idle,
	input wire fpu_pkg::instr_t ir,
	input wire fpu_pkg::value_t a,
	input wire fpu_pkg::value_t b,
	// Third operand of the instruction format, no kept operation reads it
	input wire fpu_pkg::value_t c,
	output fpu_pkg::value_t o,
	output logic done
);

	fpu_op_if u_op ();
	fpu_cand_if u_cand ();

	// Classifies the instruction and flags a change of arguments
	fpu_decode u_decode (
		.clk(clk),
		.rst(rst),
		.ir(ir),
		.a(a),
		.b(b),
		.opi(u_op.decode)
	);

	fpu_execute u_execute (
		.clk(clk),
		.rst(rst),
		.opi(u_op.exec),
		.cand(u_cand.exec)
	);

	// Picks the candidate and times the done level
	fpu_result u_result (
		.clk(clk),
		.rst(rst),
		.idle(idle),
		.opi(u_op.result),
		.cand(u_cand.result),
		.o(o),
		.done(done)
	);

endmodule

`default_nettype wire

// File: tb_fpu.sv
/*
 * Testbench of the floating-point execution unit
 * Reference model and LFSR operands biased toward special values
 * Falling-edge stimulus, a compare process and a watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module tb_fpu;
	import fpu_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYC = 3;
	localparam int IDLE_CYC = 6;
	localparam int N_ROUNDS = 40;
	// Eight one-operand ops, eight two-operand ops and one foreign opcode
	localparam int N_KINDS = 17;
	localparam int N_OPS = N_ROUNDS * N_KINDS + IDLE_CYC;
	localparam int WATCHDOG_CYC = N_OPS * 6 + RST_CYC;

	logic clk;
	logic rst;
	logic idle;
	instr_t ir;
	value_t a;
	value_t b;
	value_t c;
	value_t o;
	logic done;

	logic [31:0] lfsr;
	value_t exp_o;
	int exp_lat;
	bit exp_flags;
	event op_sent;
	event op_checked;

	fpu_top dut (
		.clk(clk), .rst(rst), .idle(idle), .ir(ir),
		.a(a), .b(b), .c(c), .o(o), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ========================================================================
	// Stimulus sources
	// ========================================================================
	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic value_t special_value(input logic [3:0] idx);
		case (idx)
			4'd0: return 32'h0000_0000;
			4'd1: return 32'h8000_0000;
			4'd2: return 32'h7F80_0000;
			4'd3: return 32'hFF80_0000;
			4'd4: return 32'h7FC0_0000;
			4'd5: return 32'hFFC0_0001;
			4'd6: return 32'h7F80_0001;
			4'd7: return 32'h3F80_0000;
			4'd8: return 32'hBF80_0000;
			// Both edges of the signed 32-bit range
			4'd9: return 32'h4F00_0000;
			4'd10: return 32'hCF00_0000;
			4'd11: return 32'hCF00_0001;
			4'd12: return 32'h4EFF_FFFF;
			4'd13: return 32'h0000_0001;
			4'd14: return 32'h3F7F_FFFF;
			default: return 32'h4B00_0001;
		endcase
	endfunction

	function automatic value_t gen_operand();
		logic [2:0] kind;
		logic [31:0] fr;
		value_t v;
		int e;
		kind = 3'(next_bits(3));
		v = next_bits(32);
		case (kind)
			3'd4: v = special_value(4'(next_bits(4)));
			3'd5: begin
				// Integral value, only the top e fraction bits may be set
				e = int'(next_bits(5)) % 24;
				fr = next_bits(23) << (23 - e);
				v = {v[31], 8'(BIAS + e), fr[22:0]};
			end
			3'd6: v = {v[31], 8'd157 + 8'(next_bits(1)), v[22:0]};
			// Half subnormals, zeros, infinities and NaNs in the low half
			3'd7: v[14:10] = next_bits(1) ? 5'h1F : 5'h00;
			default: ;
		endcase
		return v;
	endfunction

	// Second operand equals a or its negation often enough to hit eq and +-0
	function automatic value_t pick_b(input value_t x);
		logic [1:0] sel;
		sel = 2'(next_bits(2));
		if (sel == 2'd0) return x;
		if (sel == 2'd1) return x ^ 32'h8000_0000;
		return gen_operand();
	endfunction

	function automatic instr_t gen_ir(input int kind);
		logic [12:0] mid;
		logic [6:0] opc;
		func_t fn;
		func_t sub;
		mid = 13'(next_bits(13));
		opc = OP_FLT3;
		fn = FN_FLT1;
		sub = 6'(next_bits(6));
		case (kind)
			0: sub = FN_FABS;
			1: sub = FN_FNEG;
			2: sub = FN_FSIGN;
			3: sub = FN_FTOI;
			4: sub = FN_ISNAN;
			5: sub = FN_FINITE;
			6: sub = FN_FTRUNC;
			7: sub = FN_FCVTH2S;
			8: fn = FN_FSEQ;
			9: fn = FN_FSNE;
			10: fn = FN_FSLT;
			11: fn = FN_FSLE;
			12: fn = FN_FCMP;
			13: fn = FN_SGNJ;
			14: fn = FN_SGNJN;
			15: fn = FN_SGNJX;
			default: begin
				opc = 7'(next_bits(7));
				if (opc == OP_FLT3) opc[0] = ~opc[0];
			end
		endcase
		return {fn, sub, mid, opc};
	endfunction

	// ========================================================================
	// Reference model
	// ========================================================================
	function automatic bit is_nan(input value_t x);
		return (x[30:23] == 8'hFF) && (x[22:0] != 0);
	endfunction

	function automatic value_t half_to_single(input logic [15:0] h);
		logic [10:0] m;
		int k;
		m = {1'b0, h[9:0]};
		k = 0;
		if (h[14:10] == 5'h1F) return {h[15], 8'hFF, h[9:0], 13'd0};
		if (h[14:10] != 5'd0) return {h[15], 8'(h[14:10] + 112), h[9:0], 13'd0};
		if (h[9:0] == 10'd0) return {h[15], 31'd0};
		// Shift the subnormal until the hidden bit appears
		while (!m[10]) begin
			m = m << 1;
			k++;
		end
		return {h[15], 8'(113 - k), m[9:0], 13'd0};
	endfunction

	// FTOI takes two edges and FTRUNC one, everything else is combinational
	function automatic int latency_model(input instr_t i);
		if (i[6:0] != OP_FLT3 || i[31:26] != FN_FLT1) return 0;
		if (i[25:20] == FN_FTOI) return 2;
		if (i[25:20] == FN_FTRUNC) return 1;
		return 0;
	endfunction

	function automatic value_t fpu_model(input instr_t i, input value_t x, input value_t y);
		longint kx;
		longint ky;
		longint mag;
		int e;
		bit unord;
		bit eq;
		bit lt;
		// Map each value onto a signed key, both zeros land on key 0
		kx = x[31] ? -longint'(x[30:0]) : longint'(x[30:0]);
		ky = y[31] ? -longint'(y[30:0]) : longint'(y[30:0]);
		unord = is_nan(x) || is_nan(y);
		eq = !unord && (kx == ky);
		lt = !unord && (kx < ky);
		e = int'(x[30:23]) - BIAS;
		if (i[6:0] != OP_FLT3) return '0;
		case (i[31:26])
			FN_FSEQ: return {31'd0, eq};
			FN_FSNE: return {31'd0, !eq};
			FN_FSLT: return {31'd0, lt};
			FN_FSLE: return {31'd0, eq || lt};
			FN_FCMP: return {28'd0, unord, eq || lt, lt, eq};
			FN_SGNJ: return {x[31], y[30:0]};
			FN_SGNJN: return {!x[31], y[30:0]};
			FN_SGNJX: return {x[31] ^ y[31], y[30:0]};
			FN_FLT1: ;
			default: return '0;
		endcase
		case (i[25:20])
			FN_FABS: return {1'b0, x[30:0]};
			FN_FNEG: return x ^ 32'h8000_0000;
			FN_FSIGN: begin
				if (is_nan(x)) return x;
				if (x[30:0] == 0) return '0;
				return {x[31], 31'h3F80_0000};
			end
			FN_FTOI: begin
				if (is_nan(x)) return 32'h7FFF_FFFF;
				if (e < 0) return '0;
				if (e >= 31) return x[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
				mag = (longint'({1'b1, x[22:0]}) << e) >> 23;
				return x[31] ? 32'(-mag) : 32'(mag);
			end
			FN_ISNAN: return {31'd0, is_nan(x)};
			FN_FINITE: return {31'd0, x[30:23] != 8'hFF};
			FN_FTRUNC: begin
				if (e < 0) return {x[31], 31'd0};
				if (e >= 23) return x;
				return {x[31:23], (x[22:0] >> (23 - e)) << (23 - e)};
			end
			FN_FCVTH2S: return half_to_single(x[15:0]);
			default: return '0;
		endcase
	endfunction

	// ========================================================================
	// Driving, checking and the watchdog
	// ========================================================================
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "stopping at the first failing check");
	endtask

	// Drives one operation and hands its expected result to the checker
	task automatic apply_op(input instr_t nir, input value_t na, input value_t nb);
		@(negedge clk);
		idle = 1'b0;
		ir = nir;
		a = na;
		b = nb;
		c = next_bits(32);
		exp_o = fpu_model(nir, na, nb);
		exp_lat = latency_model(nir);
		exp_flags = (nir[6:0] == OP_FLT3) && (nir[31:26] == FN_FCMP);
		-> op_sent;
		@(op_checked);
	endtask

	initial begin : compare_proc
		int edges;
		forever begin
			@(op_sent);
			#1;
			edges = 0;
			// Count rising edges until done, which also catches an early done
			while (done !== 1'b1 && edges < 4) begin
				@(posedge clk);
				#1;
				edges++;
			end
			assert (done === 1'b1)
			else report_failure($sformatf("done did not rise within %0d clock edges", edges));
			assert (edges == exp_lat)
			else report_failure($sformatf("ERR done edges: got %h expected %h", edges, exp_lat));
			if (exp_flags) begin
				for (int k = 0; k < 4; k++) begin
					assert (o[k] === exp_o[k])
					else report_failure($sformatf("ERR o[%0d]: got %h expected %h",
						k, o[k], exp_o[k]));
				end
			end
			assert (o === exp_o)
			else report_failure($sformatf("ERR o: got %h expected %h (ir %h a %h b %h)",
				o, exp_o, ir, a, b));
			-> op_checked;
		end
	end

	initial begin : stimulus
		instr_t nir;
		value_t na;
		value_t nb;
		lfsr = 32'h71ad_4427;
		rst = 1'b1;
		idle = 1'b1;
		ir = '0;
		a = '0;
		b = '0;
		c = '0;
		repeat (RST_CYC) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		assert (done === 1'b0)
		else report_failure($sformatf("ERR done: got %h expected 0", done));
		// Changing inputs while idle must never raise done
		for (int i = 0; i < IDLE_CYC; i++) begin
			@(negedge clk);
			ir = gen_ir(i);
			a = gen_operand();
			b = gen_operand();
			#1;
			assert (done === 1'b0)
			else report_failure($sformatf("ERR done: got %h expected 0 while idle", done));
		end
		// Operations follow each other with no idle gap
		for (int r = 0; r < N_ROUNDS; r++) begin
			for (int k = 0; k < N_KINDS; k++) begin
				nir = gen_ir(k);
				na = gen_operand();
				nb = pick_b(na);
				// An unchanged argument set would not restart the latency
				if ({nir, na, nb} == {ir, a, b}) nb[0] = ~nb[0];
				apply_op(nir, na, nb);
			end
		end
		$display("No errors");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: flist.f
fpu_pkg.sv
fpu_op_if.sv
fpu_cand_if.sv
fpu_convert.sv
fpu_decode.sv
fpu_execute.sv
fpu_result.sv
fpu_top.sv
tb_fpu.sv
